//--- theiaCfgPkg.sv
// Core configuration package
// Word, row and address widths with their types

package theiaCfgPkg;

  // Widths --------------------
  localparam int WordWidth      = 32;  // One component, one bus word
  localparam int RowComps       = 3;   // Components per data row
  localparam int DataAddrWidth  = 7;   // Row address inside one bank
  localparam int InstrAddrWidth = 8;   // Instruction memory address
  localparam int CompSelWidth   = 2;   // Component select in host writes

  // Types --------------------
  typedef logic [WordWidth-1:0] wordT;

  // Packed so a whole row moves as one 96-bit value
  typedef wordT [RowComps-1:0] rowT;

  typedef logic [DataAddrWidth-1:0]  dataAddrT;
  typedef logic [InstrAddrWidth-1:0] instrAddrT;

endpackage

//--- theiaIsaPkg.sv
// Micro-code instruction set package
// Opcodes, instruction word layout and host address tags

package theiaIsaPkg;

  // Opcodes --------------------
  typedef enum logic [3:0] {
    OpNop = 4'h0,  // Advance only
    OpAdd = 4'h1,  // dst = a + b per component
    OpSub = 4'h2,  // dst = a - b per component
    OpMul = 4'h3,  // dst = a * b, low 32 bits kept
    OpMov = 4'h4,  // dst = a
    OpOut = 4'h5,  // Row a to output memory at dst
    OpRet = 4'h6   // End of shader
  } opcodeT;

  // Instruction word, opcode in the top nibble
  typedef struct packed {
    opcodeT     opcode;  // [31:28]
    logic [6:0] dst;     // [27:21]
    logic [6:0] srcA;    // [20:14]
    logic [6:0] srcB;    // [13:7]
    logic [6:0] unused;  // [6:0] reserved
  } instrT;

  // Address tags on the config slave --------------------
  localparam logic [1:0] TgaInstr = 2'd1;  // Write goes to instruction memory
  localparam logic [1:0] TgaData  = 2'd0;  // Write goes to a data row component

endpackage

//--- syncRam.sv
// Simple dual-port RAM, one write and one registered read
// Payload type set per instance

`timescale 1ns/1ps

module syncRam #(
  parameter type payloadT = logic [31:0],
  parameter int  Depth    = 256
) (
  input  logic                     clock,
  input  logic                     we,
  input  logic [$clog2(Depth)-1:0] wrAdr,
  input  payloadT                  wrData,
  input  logic [$clog2(Depth)-1:0] rdAdr,
  output payloadT                  rdData
);

  payloadT mem [Depth];

  // Read returns old contents on a same-address write
  always_ff @(posedge clock) begin
    if (we) begin
      mem[wrAdr] <= wrData;
    end
    rdData <= mem[rdAdr];  // One cycle latency
  end

endmodule

//--- hostSlave.sv
// Wishbone-style configuration slave
// Instruction writes pass whole, data components assemble into rows

`timescale 1ns/1ps

module hostSlave import theiaCfgPkg::*, theiaIsaPkg::*; (
  input  logic       clock,
  input  logic       arstN,
  input  logic       mst,
  input  wordT       wbDat,
  input  wordT       wbAdr,
  input  logic [1:0] wbTga,
  input  logic       wbWe,
  input  logic       wbStb,
  input  logic       wbCyc,
  output logic       wbAck,
  output logic       instrWe,
  output instrAddrT  instrAdr,
  output instrT      instrData,
  output logic       hostRowWe,
  output dataAddrT   hostRowAdr,
  output rowT        hostRow      // Also the component buffer
);

  localparam logic [CompSelWidth-1:0] LastComp = CompSelWidth'(RowComps - 1);

  logic                    accept;
  logic                    isInstr;
  logic                    isData;
  logic [CompSelWidth-1:0] compSel;
  logic                    rowPend;  // Last component taken, row write next

  // No new strobe taken while ack is out
  assign accept  = mst & wbCyc & wbStb & wbWe & ~wbAck;
  assign isInstr = (wbTga == TgaInstr);
  assign isData  = (wbTga == TgaData);
  assign compSel = wbAdr[CompSelWidth-1:0];

  // Handshake and write strobes --------------------
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      wbAck     <= 1'b0;
      instrWe   <= 1'b0;
      rowPend   <= 1'b0;
      hostRowWe <= 1'b0;
    end else begin
      wbAck     <= accept;               // One-cycle pulse
      instrWe   <= accept & isInstr;
      rowPend   <= accept & isData & (compSel == LastComp);
      hostRowWe <= rowPend;              // Commit one cycle after the ack
    end
  end

  // Payload capture --------------------
  always_ff @(posedge clock) begin
    if (accept && isInstr) begin
      instrAdr  <= wbAdr[InstrAddrWidth-1:0];
      instrData <= instrT'(wbDat);
    end
    // Select 3 has no component and is dropped
    if (accept && isData && compSel <= LastComp) begin
      hostRow[compSel] <= wbDat;
      hostRowAdr       <= wbAdr[CompSelWidth +: DataAddrWidth];  // Row above comp bits
    end
  end

endmodule

//--- controlUnit.sv
// Run sequencer for the shader core
// Bank flip, execution trigger and result commit pulses

`timescale 1ns/1ps

module controlUnit (
  input  logic clock,
  input  logic arstN,
  input  logic mst,
  input  logic renderEn,
  input  logic hda,
  input  logic exeDone,
  output logic flip,     // Bank flip, also hdl at the top
  output logic trigger,  // Start the shader at address zero
  output logic rcommit
);

  typedef enum logic [1:0] {
    StIdle,   // Waiting for render request
    StFlip,   // Banks swap this cycle
    StStart,  // Kick the execution unit
    StWait    // Shader running
  } stateT;

  stateT state;
  stateT stateNext;
  logic  runReq;

  // Host keeps the core while mst is high
  assign runReq = renderEn & hda & ~mst;

  // Next state --------------------
  always_comb begin
    stateNext = state;
    unique case (state)
      StIdle:  if (runReq) stateNext = StFlip;
      StFlip:  stateNext = StStart;
      StStart: stateNext = StWait;
      StWait:  if (exeDone) stateNext = StIdle;  // Variable latency
      default: stateNext = StIdle;
    endcase
  end

  // State and commit register --------------------
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state   <= StIdle;
      rcommit <= 1'b0;
    end else begin
      state   <= stateNext;
      rcommit <= (state == StWait) & exeDone;  // Cycle after done
    end
  end

  // Single-cycle pulses decoded from state
  assign flip    = (state == StFlip);
  assign trigger = (state == StStart);

endmodule

//--- memoryUnit.sv
// Memory unit of the shader core
// Instruction RAM, banked dual-read data RAM and write merge

`timescale 1ns/1ps

module memoryUnit import theiaCfgPkg::*, theiaIsaPkg::*; #(
  parameter int InstrDepth = 256,
  parameter int DataDepth  = 128   // Rows per bank
) (
  input  logic      clock,
  input  logic      arstN,
  input  logic      flip,
  input  logic      instrWe,
  input  instrAddrT instrAdr,
  input  instrT     instrData,
  input  logic      hostRowWe,
  input  dataAddrT  hostRowAdr,
  input  rowT       hostRow,
  input  instrAddrT pc,
  input  dataAddrT  exeRdAdrA,
  input  dataAddrT  exeRdAdrB,
  input  logic      exeWe,
  input  dataAddrT  exeWrAdr,
  input  rowT       exeWrRow,
  output instrT     instr,
  output rowT       rowA,
  output rowT       rowB
);

  localparam int DataRamDepth = 2 * DataDepth;            // Both banks
  localparam int DataRamAw    = $clog2(DataRamDepth);

  logic                  bank;       // Bank owned by the host
  logic                  dataWe;
  logic [DataRamAw-1:0]  dataWrAdr;
  rowT                   dataWrRow;
  logic [DataRamAw-1:0]  dataRdAdr [2];
  rowT                   dataRdRow [2];

  // Bank bit --------------------
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) bank <= 1'b0;
    else if (flip) bank <= ~bank;
  end

  // Host and execution write different banks, host side first
  assign dataWe    = hostRowWe | exeWe;
  assign dataWrAdr = hostRowWe ? {bank, hostRowAdr} : {~bank, exeWrAdr};
  assign dataWrRow = hostRowWe ? hostRow : exeWrRow;

  // Execution reads always go to the other bank
  assign dataRdAdr[0] = {~bank, exeRdAdrA};
  assign dataRdAdr[1] = {~bank, exeRdAdrB};

  syncRam #(.payloadT(instrT), .Depth(InstrDepth)) instrRam (
    .clock, .we(instrWe), .wrAdr(instrAdr), .wrData(instrData),
    .rdAdr(pc), .rdData(instr)
  );

  // Two copies with identical writes, one per read port
  for (genvar c = 0; c < 2; c++) begin : gDataCopy
    syncRam #(.payloadT(rowT), .Depth(DataRamDepth)) dataRam (
      .clock, .we(dataWe), .wrAdr(dataWrAdr), .wrData(dataWrRow),
      .rdAdr(dataRdAdr[c]), .rdData(dataRdRow[c])
    );
  end

  assign rowA = dataRdRow[0];
  assign rowB = dataRdRow[1];

endmodule

//--- executionUnit.sv
// Micro-code execution unit
// Fetch, operand read and execute phases over three-component rows

`timescale 1ns/1ps

module executionUnit import theiaCfgPkg::*, theiaIsaPkg::*; (
  input  logic      clock,
  input  logic      arstN,
  input  logic      trigger,
  input  instrT     instr,    // Valid from the read phase on
  input  rowT       rowA,     // Valid in the execute phase
  input  rowT       rowB,
  output instrAddrT pc,
  output dataAddrT  rdAdrA,
  output dataAddrT  rdAdrB,
  output logic      we,
  output dataAddrT  wrAdr,
  output rowT       wrRow,
  output rowT       omemDat,
  output dataAddrT  omemAdr,
  output logic      omemWe,
  output logic      done
);

  typedef enum logic [1:0] {
    PhIdle,
    PhFetch,  // pc presented to instruction RAM
    PhRead,   // Source rows addressed
    PhExec    // Result and side effects
  } phaseT;

  phaseT phase;
  logic  inExec;
  logic  isRet;
  logic  isArith;
  rowT   result;

  assign inExec  = (phase == PhExec);
  assign isRet   = (instr.opcode == OpRet);
  assign isArith = (instr.opcode inside {OpAdd, OpSub, OpMul, OpMov});

  // Phase sequencer and program counter --------------------
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      phase <= PhIdle;
      pc    <= '0;
    end else begin
      unique case (phase)
        PhIdle: begin
          if (trigger) begin
            pc    <= '0;        // Entry fixed at zero
            phase <= PhFetch;
          end
        end
        PhFetch: phase <= PhRead;
        PhRead:  phase <= PhExec;
        PhExec: begin
          if (isRet) begin
            phase <= PhIdle;
          end else begin
            pc    <= pc + 1'b1;
            phase <= PhFetch;
          end
        end
        default: phase <= PhIdle;
      endcase
    end
  end

  // Operand addresses straight from the instruction word
  assign rdAdrA = instr.srcA;
  assign rdAdrB = instr.srcB;

  // Component-wise datapath --------------------
  always_comb begin
    result = rowA;                            // Mov and the fallback
    for (int i = 0; i < RowComps; i++) begin
      unique case (instr.opcode)
        OpAdd:   result[i] = rowA[i] + rowB[i];
        OpSub:   result[i] = rowA[i] - rowB[i];
        OpMul:   result[i] = rowA[i] * rowB[i];  // Low 32 bits
        default: result[i] = rowA[i];
      endcase
    end
  end

  // Data memory write back
  assign we    = inExec & isArith;
  assign wrAdr = instr.dst;
  assign wrRow = result;

  // Output memory port, source A row to dst
  assign omemWe  = inExec & (instr.opcode == OpOut);
  assign omemAdr = instr.dst;
  assign omemDat = rowA;

  assign done = inExec & isRet;  // Single pulse to control

endmodule

//--- theiaCore.sv
// Ray-cast shader core top level
// Host slave, control, memory and execution units with their links

`timescale 1ns/1ps

module theiaCore import theiaCfgPkg::*, theiaIsaPkg::*; #(
  parameter int InstrDepth = 256,  // Instruction words
  parameter int DataDepth  = 128   // Rows per data bank
) (
  input  logic       clock,
  input  logic       arstN,
  input  logic       mst,       // Host owns the core, config mode
  input  wordT       wbDat,
  input  wordT       wbAdr,
  input  logic [1:0] wbTga,
  input  logic       wbWe,
  input  logic       wbStb,
  input  logic       wbCyc,
  output logic       wbAck,
  input  logic       renderEn,
  input  logic       hda,       // Host data available
  output logic       hdl,       // Host data latched, bank flipped
  output logic       rcommit,   // Result committed
  output rowT        omemDat,
  output dataAddrT   omemAdr,
  output logic       omemWe
);

  // Host to memory
  logic      instrWe;
  instrAddrT instrAdr;
  instrT     instrData;
  logic      hostRowWe;
  dataAddrT  hostRowAdr;
  rowT       hostRow;

  // Control links
  logic flip;
  logic trigger;
  logic exeDone;

  // Execution to memory and back
  instrAddrT pc;
  instrT     instr;
  dataAddrT  exeRdAdrA;
  dataAddrT  exeRdAdrB;
  rowT       rowA;
  rowT       rowB;
  logic      exeWe;
  dataAddrT  exeWrAdr;
  rowT       exeWrRow;

  assign hdl = flip;  // Flip doubles as data-latched to the host

  hostSlave hostIo (
    .clock, .arstN, .mst,
    .wbDat, .wbAdr, .wbTga, .wbWe, .wbStb, .wbCyc, .wbAck,
    .instrWe, .instrAdr, .instrData,
    .hostRowWe, .hostRowAdr, .hostRow
  );

  controlUnit ctrl (
    .clock, .arstN, .mst, .renderEn, .hda,
    .exeDone, .flip, .trigger, .rcommit
  );

  memoryUnit #(
    .InstrDepth (InstrDepth),
    .DataDepth  (DataDepth)
  ) mem (
    .clock, .arstN, .flip,
    .instrWe, .instrAdr, .instrData,
    .hostRowWe, .hostRowAdr, .hostRow,
    .pc, .exeRdAdrA, .exeRdAdrB,
    .exeWe, .exeWrAdr, .exeWrRow,
    .instr, .rowA, .rowB
  );

  executionUnit exe (
    .clock, .arstN, .trigger, .instr, .rowA, .rowB,
    .pc, .rdAdrA(exeRdAdrA), .rdAdrB(exeRdAdrB),
    .we(exeWe), .wrAdr(exeWrAdr), .wrRow(exeWrRow),
    .omemDat, .omemAdr, .omemWe, .done(exeDone)
  );

endmodule

//--- theiaCore_sva.sv
// Bound checker on core handshake pulses

`timescale 1ns/1ps

module theiaCoreChecker (
  input logic clock,
  input logic arstN,
  input logic mst,
  input logic wbAck,
  input logic hdl,
  input logic rcommit,
  input logic omemWe
);

  // Ack is a single-cycle pulse
  ackPulse: assert property (@(posedge clock) disable iff (!arstN) wbAck |=> !wbAck)
    else $error("wbAck held high");

  // Latch and commit never overlap
  noOverlap: assert property (@(posedge clock) disable iff (!arstN) !(hdl && rcommit))
    else $error("hdl and rcommit together");

  // No output writes in config mode
  outNoMst: assert property (@(posedge clock) disable iff (!arstN) $rose(omemWe) |-> !mst)
    else $error("omemWe rose with mst high");

  ackNeedsMst: assert property (@(posedge clock) disable iff (!arstN) wbAck |-> $past(mst))
    else $error("wbAck without mst");

endmodule

bind theiaCore theiaCoreChecker checkerInst (.*);

//--- theiaCore_tb.sv
// Testbench for the shader core
// Stim-file driven host writes, runs and output row checks

`timescale 1ns/1ps

module theiaCore_tb import theiaCfgPkg::*, theiaIsaPkg::*;;

  localparam int AckTimeout = 8;    // Cycles allowed for a wbAck
  localparam int RunTimeout = 400;  // Cycles allowed for hdl or rcommit

  logic clock = 1'b0;
  logic arstN;
  logic mst, wbWe, wbStb, wbCyc, wbAck;
  wordT wbDat, wbAdr;
  logic [1:0] wbTga;
  logic renderEn, hda, hdl, rcommit, omemWe;
  rowT omemDat;
  dataAddrT omemAdr;

  int seed;
  int errors = 0;
  int tests = 0;
  int failedTests = 0;
  dataAddrT outAdr [$];  // Rows seen on the output port
  rowT outRow [$];

  always #2 clock = ~clock;  // 4 ns period

  theiaCore dut_i (.*);

  // Test bookkeeping --------------------
  task automatic finishTest(input string name, input int errBefore);
    tests++;
    if (errors != errBefore) failedTests++;
    $display("test %0d %s: %s", tests, name, (errors == errBefore) ? "ok" : "failed");
  endtask

  // Host write in config mode
  // Ack expected one cycle after the strobe is taken
  task automatic busWrite(input logic [1:0] tga, input wordT adr, input wordT dat);
    int waitCyc;
    bit gotAck;
    @(posedge clock);
    mst   <= 1'b1;
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe  <= 1'b1;
    wbTga <= tga;
    wbAdr <= adr;
    wbDat <= dat;
    waitCyc = 0;
    gotAck = 1'b0;
    while (!gotAck && waitCyc < AckTimeout) begin
      @(negedge clock);
      waitCyc++;
      gotAck = wbAck;
    end
    @(posedge clock);
    wbCyc <= 1'b0;  // Strobe drops in the ack cycle
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
    if (!gotAck) begin
      $display("timeout: host write to address %h got no wbAck", adr);
      errors++;
    end else begin
      assert (waitCyc == 2) else begin
        $display("error %0t: wbAck came %0d samples after strobe", $time, waitCyc);
        errors++;
      end
    end
    @(negedge clock);
    assert (!wbAck) else begin
      $display("error %0t: wbAck longer than one cycle", $time);
      errors++;
    end
  endtask

  // Strobe with mst low must stay unanswered
  task automatic ignoredWrite(input wordT adr, input wordT dat);
    @(posedge clock);
    mst   <= 1'b0;
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe  <= 1'b1;
    wbTga <= TgaData;
    wbAdr <= adr;
    wbDat <= dat;
    for (int i = 0; i < AckTimeout; i++) begin
      @(negedge clock);
      assert (!wbAck) else begin
        $display("error %0t: wbAck without mst", $time);
        errors++;
      end
    end
    @(posedge clock);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  // One shader run collecting output rows until rcommit
  task automatic runShader();
    int cyc;
    int delay;
    int earlyOut;
    int hdlCount;
    bit seen;
    @(posedge clock);
    mst <= 1'b0;
    delay = $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
    repeat (delay) @(posedge clock);
    renderEn <= 1'b1;
    hda <= 1'b1;
    cyc = 0;
    earlyOut = 0;
    seen = 1'b0;
    while (!seen && cyc < RunTimeout) begin
      @(negedge clock);
      cyc++;
      if (omemWe) earlyOut++;
      seen = hdl;
    end
    if (!seen) begin
      $display("timeout: run start never raised hdl");
      errors++;
      return;
    end
    @(posedge clock);
    renderEn <= 1'b0;
    hda <= 1'b0;  // Lowered well before rcommit
    cyc = 0;
    hdlCount = 1;
    seen = 1'b0;
    while (!seen && cyc < RunTimeout) begin
      @(negedge clock);
      cyc++;
      if (hdl) hdlCount++;
      if (omemWe) begin
        outAdr.push_back(omemAdr);
        outRow.push_back(omemDat);
      end
      seen = rcommit;
      assert (!(omemWe && rcommit)) else begin
        $display("error %0t: omemWe together with rcommit", $time);
        errors++;
      end
    end
    if (!seen) begin
      $display("timeout: shader run never reached rcommit");
      errors++;
    end
    assert (hdlCount == 1 && earlyOut == 0) else begin
      $display("error %0t: %0d hdl pulses, %0d rows before hdl", $time, hdlCount, earlyOut);
      errors++;
    end
  endtask

  // Main sequence --------------------
  initial begin
    int fd;
    int errBefore;
    byte kind;
    wordT f1, f2, f3, f4;
    string line;
    dataAddrT gotAdr;
    rowT gotRow;
    rowT expRow;
    seed = 71;
    arstN = 1'b0;
    mst = 1'b0;
    wbWe = 1'b0;
    wbStb = 1'b0;
    wbCyc = 1'b0;
    wbDat = '0;
    wbAdr = '0;
    wbTga = TgaData;
    renderEn = 1'b0;
    hda = 1'b0;
    repeat (16) @(posedge clock);
    arstN <= 1'b1;
    @(negedge clock);
    errBefore = errors;
    assert (!hdl && !rcommit && !omemWe && !wbAck) else begin
      $display("error %0t: outputs not low after reset", $time);
      errors++;
    end
    finishTest("reset", errBefore);
    fd = $fopen("theiaCore_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
        void'($sscanf(line, "%c %h %h %h %h", kind, f1, f2, f3, f4));
        errBefore = errors;
        case (kind)
          "I": begin
            busWrite(TgaInstr, f1, f2);
            finishTest("instr write", errBefore);
          end
          "D": begin
            busWrite(TgaData, (f1 << CompSelWidth) | f2, f3);  // Row above comp bits
            finishTest("data write", errBefore);
          end
          "N": begin
            ignoredWrite((f1 << CompSelWidth) | f2, f3);
            finishTest("write without mst", errBefore);
          end
          "R": begin
            // Earlier rows must all be matched by E lines
            assert (outAdr.size() == 0) else begin
              $display("error %0t: %0d unexpected output rows", $time, outAdr.size());
              errors++;
            end
            outAdr.delete();
            outRow.delete();
            runShader();
            finishTest("run", errBefore);
          end
          "E": begin
            expRow[0] = f2;
            expRow[1] = f3;
            expRow[2] = f4;
            if (outAdr.size() == 0) begin
              $display("expected output row at %h never appeared", f1);
              errors++;
            end else begin
              gotAdr = outAdr.pop_front();
              gotRow = outRow.pop_front();
              assert (gotAdr == dataAddrT'(f1) && gotRow == expRow) else begin
                $display("error %0t: row %h = %h, expected %h = %h",
                         $time, gotAdr, gotRow, f1, expRow);
                errors++;
              end
            end
            finishTest("output row", errBefore);
          end
          default: begin
            $display("unknown stimulus line: %s", line);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    assert (outAdr.size() == 0) else begin
      $display("error %0t: leftover output rows at end", $time);
      errors++;
    end
    $display("%0d tests, %0d failed, %0d errors", tests, failedTests, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- theiaCore_stim.txt
# I addr word | D row comp word | N row comp word (no mst)
# R starts a run | E omemAdr comp0 comp1 comp2 (all hex)
D 00 0 11111111
D 00 1 22222222
D 00 2 33333333
D 01 0 00000005
D 01 1 FFFFFFFF
D 01 2 00000010
D 02 0 00000003
D 02 1 00000002
D 02 2 00000020
N 00 0 DEADBEEF
N 00 1 DEADBEEF
N 00 2 DEADBEEF
I 00 11404100
I 01 21604100
I 02 31804100
I 03 41A28000
I 04 52828000
I 05 52A2C000
I 06 52C30000
I 07 52E34000
I 08 53000000
I 09 60000000
R
E 14 00000008 00000001 00000030
E 15 00000002 FFFFFFFD FFFFFFF0
E 16 0000000F FFFFFFFE 00000200
E 17 00000008 00000001 00000030
E 18 11111111 22222222 33333333
D 0A 0 AAAA0001
D 0A 1 BBBB0002
D 0A 2 CCCC0003
D 03 0 00000001
D 03 1 00000001
D 03 2 00000001
I 00 11C28180
I 01 53228000
I 02 53438000
I 03 60000000
R
E 19 AAAA0001 BBBB0002 CCCC0003
E 1A AAAA0002 BBBB0003 CCCC0004

//--- filelist.f
theiaCfgPkg.sv
theiaIsaPkg.sv
syncRam.sv
hostSlave.sv
controlUnit.sv
memoryUnit.sv
executionUnit.sv
theiaCore.sv
theiaCore_sva.sv
theiaCore_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = theiaCore_tb
FILELIST = filelist.f

SOURCES  = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) theiaCore_stim.txt
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
